/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= flist.f
OBJ_DIR   ?= obj_dir
LINTFLAGS ?= --lint-only --timing --assert
SIMFLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation binary is the verdict
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
verilog/fetch_pkg.sv
verilog/pc_ctrl.sv
verilog/instr_rom.sv
verilog/predecode.sv
verilog/fetch_top.sv
tb/tb_clock.sv
tb/tb_fetch_top.sv

/* tb/program.hex */
// One 32-bit instruction word per line in hex
// Line i holds the word at reset_pc + 4*i
00100093 // addi x1, x0, 1
00108133 // add x2, x1, x1
12345297 // auipc x5, 0x12345
00208463 // beq x1, x2, 8
008000EF // jal x1, +8
00000013 // nop
FFFFF317 // auipc x6, 0xfffff
010280E7 // jalr x1, 16(x5)
00000013 // nop
00310193 // addi x3, x2, 3
00C0006F // jal x0, +12
FE209EE3 // bne x1, x2, -4
FF808067 // jalr x0, -8(x1)
40208233 // sub x4, x1, x2
00000517 // auipc x10, 0
008000EF // jal x1, +8
00000013 // nop
00C000E7 // jalr x1, 12(x0)
0020A023 // sw x2, 0(x1)
00000013 // nop
FE000EE3 // beq x0, x0, -4
80000537 // lui x10, 0x80000
00000013 // nop
FA5FF06F // jal x0, -92

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	// Half of the 100 ns period
	localparam int half_period = 50;

	// Cycles spent in reset
	localparam int reset_cycles = 8;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Active low, let go on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		reset <= 1'b1;
	end

endmodule

/* tb/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

	// Run length and the safety limit derived from it
	localparam int run_cycles     = 400;
	localparam int timeout_cycles = run_cycles * 5 / 4;
	localparam logic [15:0] lfsr_seed = 16'd38257;

	// Words actually present in the program image
	localparam logic [4:0] prog_words = 5'd24;

	// Expected fetch for one PC
	typedef struct packed {
		logic [xlen-1:0] word;
		instr_class_e    cls;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] next_pc;
		logic [xlen-1:0] pc_save;
	} fetch_ref_t;

	logic         clk;
	logic         reset;
	logic         bubble;
	redirect_t    redirect;
	fetch_word_t  fetch;
	decode_info_t info;
	logic [xlen-1:0] current_pc;
	logic [xlen-1:0] pc_save;

	// Program image from the same file as the ROM
	logic [xlen-1:0] prog [rom_depth];

	// Model state as it stands after the last rising edge
	logic            exp_valid = 1'b0;
	logic [xlen-1:0] exp_pc    = reset_pc;

	logic [15:0] lfsr;
	int          cycle_count = 0;

	tb_clock u_tb_clock (
		.clk   (clk),
		.reset (reset)
	);

	fetch_top u_fetch_top (
		.clk        (clk),
		.reset      (reset),
		.bubble     (bubble),
		.redirect   (redirect),
		.fetch      (fetch),
		.info       (info),
		.current_pc (current_pc),
		.pc_save    (pc_save)
	);

	initial begin
		$readmemh(rom_file, prog);
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Word offset from reset_pc wrapped on the ROM size
	function automatic int word_index(input logic [xlen-1:0] pc);
		logic [xlen-1:0] offset;
		offset = pc - reset_pc;
		return int'((offset >> 2) % rom_depth);
	endfunction

	function automatic fetch_ref_t fetch_ref(input logic [xlen-1:0] pc);
		fetch_ref_t r;
		logic [xlen-1:0] w;
		w = prog[word_index(pc)];
		r = '0;
		r.word = w;
		r.cls = class_other;
		case (w[6:0])
			7'b1101111: begin
				r.cls = class_jal;
				r.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
			end
			7'b1100111: begin
				r.cls = class_jalr;
				r.imm = 32'($signed(w[31:20]));
			end
			7'b0010111: begin
				r.cls = class_auipc;
				r.imm = {w[31:12], 12'h000};
			end
			// Not taken so no target
			7'b1100011: r.cls = class_branch;
			default:    r.cls = class_other;
		endcase
		// Jumps leave a link and everything else saves PC plus imm
		if (r.cls == class_jal || r.cls == class_jalr) begin
			r.next_pc = pc + r.imm;
			r.pc_save = pc + 32'd4;
		end else begin
			r.next_pc = pc + 32'd4;
			r.pc_save = pc + r.imm;
		end
		return r;
	endfunction

	// Inputs read here are the ones the DUT samples at this edge
	always @(posedge clk) begin
		fetch_ref_t cur;
		cur = fetch_ref(exp_pc);
		if (!reset) begin
			exp_valid = 1'b0;
			exp_pc = reset_pc;
		end else begin
			// No valid word yet means the PC holds
			if (!bubble && exp_valid) begin
				if (redirect.misprediction) begin
					exp_pc = redirect.correct_pc;
				end else begin
					exp_pc = cur.next_pc;
				end
			end
			exp_valid = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Comparison
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [xlen-1:0] got,
			input logic [xlen-1:0] want);
		assert (got === want) else begin
			$display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// Outputs are settled mid cycle
	always @(negedge clk) begin
		fetch_ref_t want;
		want = fetch_ref(exp_pc);
		if (!exp_valid) begin
			check_value("current_pc", current_pc, reset_pc);
			check_value("fetch.valid", 32'(fetch.valid), 32'd0);
			check_value("info.cls", 32'(info.cls), 32'(class_other));
		end else begin
			check_value("fetch.valid", 32'(fetch.valid), 32'd1);
			check_value("current_pc", current_pc, exp_pc);
			check_value("fetch.instr", fetch.instr, want.word);
			check_value("info.cls", 32'(info.cls), 32'(want.cls));
			check_value("info.imm", info.imm, want.imm);
			check_value("pc_save", pc_save, want.pc_save);
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] galois_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end else begin
			return state >> 1;
		end
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
	endtask

	initial begin
		logic [15:0] bits;
		logic        stall;
		logic        mispredict;
		logic [4:0]  target_word;
		bubble = 1'b0;
		redirect = '0;
		lfsr = lfsr_seed;
		@(posedge reset);
		repeat (run_cycles) begin
			@(posedge clk);
			// Bubble about one cycle in eight
			draw_bits(3, bits);
			stall = (bits[2:0] == 3'b111);
			// Misprediction about one in sixteen and never with a bubble
			draw_bits(4, bits);
			mispredict = !stall && (bits[3:0] == 4'h0);
			// Target inside the loaded program
			draw_bits(5, bits);
			target_word = bits[4:0] % prog_words;
			bubble <= stall;
			redirect.misprediction <= mispredict;
			redirect.correct_pc <= reset_pc + {25'd0, target_word, 2'b00};
		end
		@(posedge clk);
		$display("All checks passed");
		$finish;
	end

	// Hard stop if the run never ends
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Checks failed");
			$fatal(1, "Timeout after %0d cycles, the run did not finish", cycle_count);
		end
	end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

	//////////////////////////////////////////////////
	// Widths and addresses
	//////////////////////////////////////////////////

	// Data and address width
	localparam int xlen = 32;

	// First fetch address after reset
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// Program ROM geometry
	localparam int rom_depth      = 64;
	localparam int rom_index_bits = 6;

	// Program image, relative to the run directory
	localparam string rom_file = "tb/program.hex";

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////

	// Major opcodes the predecoder cares about
	typedef enum logic [6:0] {
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_auipc  = 7'b0010111,
		op_branch = 7'b1100011
	} opcode_e;

	// Instruction class seen by the PC controller
	typedef enum logic [2:0] {
		class_jal,
		class_jalr,
		class_auipc,
		class_branch,
		class_other
	} instr_class_e;

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	// Word coming out of the instruction ROM
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] instr;
	} fetch_word_t;

	// Predecoder result
	typedef struct packed {
		instr_class_e    cls;
		logic [xlen-1:0] imm;
	} decode_info_t;

	// Correction from execute
	typedef struct packed {
		logic            misprediction;
		logic [xlen-1:0] correct_pc;
	} redirect_t;

endpackage

/* verilog/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            bubble,
	input  redirect_t       redirect,
	output fetch_word_t     fetch,
	output decode_info_t    info,
	output logic [xlen-1:0] current_pc,
	output logic [xlen-1:0] pc_save
);

	// Address for the next ROM read
	logic [xlen-1:0] inst_addr;

	//////////////////////////////////////////////////
	// PC controller
	//////////////////////////////////////////////////

	pc_ctrl u_pc_ctrl (
		.clk         (clk),
		.reset       (reset),
		.bubble      (bubble),
		.fetch_valid (fetch.valid),
		.info        (info),
		.redirect    (redirect),
		.inst_addr   (inst_addr),
		.current_pc  (current_pc),
		.pc_save     (pc_save)
	);

	//////////////////////////////////////////////////
	// Instruction memory
	//////////////////////////////////////////////////

	// One cycle from inst_addr to fetch
	instr_rom u_instr_rom (
		.clk       (clk),
		.reset     (reset),
		.inst_addr (inst_addr),
		.fetch     (fetch)
	);

	//////////////////////////////////////////////////
	// Predecoder
	//////////////////////////////////////////////////

	// Combinational, feeds class and imm back to the PC controller
	predecode u_predecode (
		.fetch (fetch),
		.info  (info)
	);

endmodule

/* verilog/instr_rom.sv */
`timescale 1ns/1ps

module instr_rom import fetch_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic [xlen-1:0] inst_addr,
	output fetch_word_t     fetch
);

	// Program storage
	logic [xlen-1:0] mem [rom_depth];

	// Word index, wraps on rom_depth
	logic [rom_index_bits-1:0] index;

	// Registered read
	logic            valid_q;
	logic [xlen-1:0] instr_q;

	initial begin
		$readmemh(rom_file, mem);
	end

	// Offset from reset_pc in words
	assign index = rom_index_bits'((inst_addr - reset_pc) >> 2);

	// Data path, no reset
	always_ff @(posedge clk) begin
		instr_q <= mem[index];
	end

	// Valid rises at first edge after reset
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b1;
		end
	end

	assign fetch.valid = valid_q;
	assign fetch.instr = instr_q;

	// PC controller only hands out word addresses
	assert property (@(posedge clk) disable iff (!reset)
		inst_addr[1:0] == 2'b00)
		else $error("unaligned inst_addr");

endmodule

/* verilog/pc_ctrl.sv */
`timescale 1ns/1ps

module pc_ctrl import fetch_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            bubble,
	input  logic            fetch_valid,
	input  decode_info_t    info,
	input  redirect_t       redirect,
	output logic [xlen-1:0] inst_addr,
	output logic [xlen-1:0] current_pc,
	output logic [xlen-1:0] pc_save
);

	// PC register
	logic [xlen-1:0] pc_q;

	// Candidate targets
	logic [xlen-1:0] pc_plus_four;
	logic [xlen-1:0] pc_plus_imm;

	// Next-PC selection stages
	logic [xlen-1:0] pc_by_class;
	logic [xlen-1:0] pc_corrected;
	logic [xlen-1:0] pc_next;

	//////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////

	// Holds on bubble, otherwise takes next PC
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc_q <= reset_pc;
		end else if (!bubble) begin
			pc_q <= pc_next;
		end
	end

	//////////////////////////////////////////////////
	// Next PC
	//////////////////////////////////////////////////

	assign pc_plus_four = pc_q + 32'd4;
	assign pc_plus_imm  = pc_q + info.imm;

	// Jumps go to PC plus imm
	// rs1 unknown at fetch, so JALR is predicted the same way
	always_comb begin
		case (info.cls)
			class_jal,
			class_jalr: pc_by_class = pc_plus_imm;
			default:    pc_by_class = pc_plus_four;
		endcase
	end

	// Misprediction wins over the class choice
	assign pc_corrected = redirect.misprediction ? redirect.correct_pc : pc_by_class;

	// Nothing fetched yet, so stay put
	assign pc_next = fetch_valid ? pc_corrected : pc_q;

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// ROM address for the coming edge
	// reset_pc during reset, current PC on bubble so the ROM rereads it
	assign inst_addr = !reset ? reset_pc : (bubble ? pc_q : pc_next);

	assign current_pc = pc_q;

	// Link address for jumps, PC plus imm otherwise
	// imm is zero for branch and other
	always_comb begin
		case (info.cls)
			class_jal,
			class_jalr: pc_save = pc_plus_four;
			default:    pc_save = pc_plus_imm;
		endcase
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Execute must not redirect into a stalled front end
	assert property (@(posedge clk) disable iff (!reset)
		!(redirect.misprediction && bubble))
		else $error("misprediction during bubble");

	// Redirect target from execute must be word aligned
	assert property (@(posedge clk) disable iff (!reset)
		redirect.misprediction |-> (redirect.correct_pc[1:0] == 2'b00))
		else $error("unaligned correct_pc");

endmodule

/* verilog/predecode.sv */
`timescale 1ns/1ps

module predecode import fetch_pkg::*; (
	input  fetch_word_t  fetch,
	output decode_info_t info
);

	// Major opcode of the fetched word
	opcode_e opcode;

	// Immediates of each format
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;

	assign opcode = opcode_e'(fetch.instr[6:0]);

	//////////////////////////////////////////////////
	// Immediate assembly
	//////////////////////////////////////////////////

	// J format, bit 0 always zero
	assign imm_j = {
		{11{fetch.instr[31]}},
		fetch.instr[31],
		fetch.instr[19:12],
		fetch.instr[20],
		fetch.instr[30:21],
		1'b0
	};

	// I format
	assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};

	// U format, low 12 bits zero
	assign imm_u = {fetch.instr[31:12], 12'b0};

	//////////////////////////////////////////////////
	// Classification
	//////////////////////////////////////////////////

	always_comb begin
		// Default covers ALU words and empty fetch
		info.cls = class_other;
		info.imm = '0;
		if (fetch.valid) begin
			case (opcode)
				op_jal: begin
					info.cls = class_jal;
					info.imm = imm_j;
				end
				op_jalr: begin
					info.cls = class_jalr;
					info.imm = imm_i;
				end
				op_auipc: begin
					info.cls = class_auipc;
					info.imm = imm_u;
				end
				// Predicted not taken, no target needed
				op_branch: begin
					info.cls = class_branch;
				end
				default: begin
					info.cls = class_other;
				end
			endcase
		end
	end

endmodule
